//--- design/spi_inst_params.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// width and size constants for the SPI instruction parser
// a data word must be exactly two link bytes wide
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SPI_INST_PARAMS_SVH
`define SPI_INST_PARAMS_SVH

// user register and RAM word
`define SPI_INST_WORD_W 16

// one SPI transfer
`define SPI_INST_BYTE_W 8

// external RAM geometry, size must equal 2**AW
`define SPI_INST_RAM_AW 8
`define SPI_INST_RAM_SIZE 256

`endif

//--- design/spi_inst_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opcode and register address encodings of the instruction set
// opcodes 4, 5 and above 7 are not decoded
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "spi_inst_params.svh"

package spi_inst_pkg;

    typedef enum logic [`SPI_INST_BYTE_W-1:0] {
        op_disable   = 8'd0,
        op_enable    = 8'd1,
        op_write_reg = 8'd2,
        op_read_reg  = 8'd3,
        op_write_ram = 8'd6,
        op_read_ram  = 8'd7
    } opcode_e;

    // sum and en are read only
    typedef enum logic [`SPI_INST_BYTE_W-1:0] {
        ra_sum  = 8'd0,
        ra_num1 = 8'd1,
        ra_num2 = 8'd2,
        ra_num3 = 8'd3,
        ra_en   = 8'd4
    } reg_addr_e;

    // word assembled from the link, low byte first
    typedef union packed {
        logic [`SPI_INST_WORD_W-1:0] word;
        struct packed {
            logic [`SPI_INST_BYTE_W-1:0] hi;
            logic [`SPI_INST_BYTE_W-1:0] lo;
        } bytes;
    } half_word_u;

endpackage

//--- design/spi_inst_ifs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// internal buses between the sequencer and its two targets
// all strobes are single-cycle pulses from the sequencer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "spi_inst_params.svh"

interface reg_access_if;

    logic                        wr_stb;
    logic                        rd_stb;
    logic [`SPI_INST_BYTE_W-1:0] addr;
    logic [`SPI_INST_WORD_W-1:0] wdata;
    // held from the last rd_stb
    logic [`SPI_INST_WORD_W-1:0] rdata;

    modport seq (output wr_stb, rd_stb, addr, wdata, input rdata);
    modport regs (input wr_stb, rd_stb, addr, wdata, output rdata);

endinterface

interface ram_access_if;

    // full 16-bit burst address, may run past the RAM
    logic [`SPI_INST_WORD_W-1:0] word_addr;
    logic                        set_waddr;
    logic                        set_raddr;
    logic                        wr_stb;
    logic [`SPI_INST_WORD_W-1:0] wdata;
    logic [`SPI_INST_WORD_W-1:0] rdata;

    modport seq (
        output word_addr, set_waddr, set_raddr, wr_stb, wdata,
        input  rdata
    );
    modport ram (
        input  word_addr, set_waddr, set_raddr, wr_stb, wdata,
        output rdata
    );

endinterface

//--- design/inst_sequencer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction FSM behind the SPI slave, one byte per trans_end
// bytes of one instruction must be at least 3 cycles apart
// a burst count of zero is not supported
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "spi_inst_params.svh"

module inst_sequencer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        trans_begin,
    input  logic                        trans_end,
    input  logic [`SPI_INST_BYTE_W-1:0] din,
    output logic [`SPI_INST_BYTE_W-1:0] dout,
    output logic                        en,
    reg_access_if.seq                   reg_bus,
    ram_access_if.seq                   ram_bus
);

    typedef enum logic [4:0] {
        S_IDLE,
        S_OPCODE,
        S_EN_UPDATE,
        S_REG_ADDR,
        S_REG_LATCH,
        S_DATA_LO,
        S_DATA_HI,
        S_REG_STORE,
        S_ADDR_LO,
        S_ADDR_HI,
        S_CNT_LO,
        S_CNT_HI,
        S_SET_WADDR,
        S_RAM_STORE,
        S_SET_RADDR,
        S_SLOT_LO,
        S_SLOT_HI,
        S_SLOT_CLOSE
    } state_e;

    state_e                      state;
    state_e                      state_nxt;
    spi_inst_pkg::opcode_e       op_q;
    spi_inst_pkg::half_word_u    word_addr;
    spi_inst_pkg::half_word_u    cnt;
    spi_inst_pkg::half_word_u    data;
    spi_inst_pkg::half_word_u    rd_word;
    logic [`SPI_INST_BYTE_W-1:0] reg_addr;
    logic                        last_word;

    assign last_word = (cnt.word == `SPI_INST_WORD_W'(1));

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:
                if (trans_begin)
                    state_nxt = S_OPCODE;
            S_OPCODE:
                if (trans_end) begin
                    case (din)
                        spi_inst_pkg::op_disable,
                        spi_inst_pkg::op_enable:    state_nxt = S_EN_UPDATE;
                        spi_inst_pkg::op_write_reg,
                        spi_inst_pkg::op_read_reg:  state_nxt = S_REG_ADDR;
                        spi_inst_pkg::op_write_ram,
                        spi_inst_pkg::op_read_ram:  state_nxt = S_ADDR_LO;
                        default:                    state_nxt = S_IDLE;
                    endcase
                end
            S_EN_UPDATE:
                state_nxt = S_IDLE;
            S_REG_ADDR:
                if (trans_end)
                    state_nxt = (op_q == spi_inst_pkg::op_read_reg) ? S_REG_LATCH : S_DATA_LO;
            S_REG_LATCH:
                state_nxt = S_SLOT_LO;
            S_DATA_LO:
                if (trans_end)
                    state_nxt = S_DATA_HI;
            S_DATA_HI:
                if (trans_end)
                    state_nxt = (op_q == spi_inst_pkg::op_write_ram) ? S_RAM_STORE : S_REG_STORE;
            S_REG_STORE:
                state_nxt = S_IDLE;
            S_ADDR_LO:
                if (trans_end)
                    state_nxt = S_ADDR_HI;
            S_ADDR_HI:
                if (trans_end)
                    state_nxt = S_CNT_LO;
            S_CNT_LO:
                if (trans_end)
                    state_nxt = S_CNT_HI;
            S_CNT_HI:
                if (trans_end)
                    state_nxt = (op_q == spi_inst_pkg::op_write_ram) ? S_SET_WADDR : S_SET_RADDR;
            S_SET_WADDR:
                state_nxt = S_DATA_LO;
            S_RAM_STORE:
                state_nxt = last_word ? S_IDLE : S_SET_WADDR;
            S_SET_RADDR:
                state_nxt = S_SLOT_LO;
            S_SLOT_LO:
                if (trans_begin)
                    state_nxt = S_SLOT_HI;
            S_SLOT_HI:
                if (trans_begin)
                    state_nxt = S_SLOT_CLOSE;
            S_SLOT_CLOSE:
                if (trans_end) begin
                    if (op_q == spi_inst_pkg::op_read_ram && !last_word)
                        state_nxt = S_SET_RADDR;
                    else
                        state_nxt = S_IDLE;
                end
            default:
                state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            op_q      <= spi_inst_pkg::op_disable;
            en        <= 1'b0;
            word_addr <= '0;
            cnt       <= '0;
        end else begin
            state <= state_nxt;
            case (state)
                S_OPCODE:
                    if (trans_end)
                        op_q <= spi_inst_pkg::opcode_e'(din);
                S_EN_UPDATE:
                    en <= (op_q == spi_inst_pkg::op_enable);
                S_ADDR_LO:
                    if (trans_end)
                        word_addr.bytes.lo <= din;
                S_ADDR_HI:
                    if (trans_end)
                        word_addr.bytes.hi <= din;
                S_CNT_LO:
                    if (trans_end)
                        cnt.bytes.lo <= din;
                S_CNT_HI:
                    if (trans_end)
                        cnt.bytes.hi <= din;
                // step to the next burst word
                S_RAM_STORE: begin
                    word_addr.word <= word_addr.word + 1'b1;
                    cnt.word       <= cnt.word - 1'b1;
                end
                S_SLOT_CLOSE:
                    if (trans_end) begin
                        word_addr.word <= word_addr.word + 1'b1;
                        cnt.word       <= cnt.word - 1'b1;
                    end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (trans_end) begin
            case (state)
                S_REG_ADDR: reg_addr      <= din;
                S_DATA_LO:  data.bytes.lo <= din;
                S_DATA_HI:  data.bytes.hi <= din;
                default: ;
            endcase
        end
    end

    assign reg_bus.wr_stb = (state == S_REG_STORE);
    assign reg_bus.rd_stb = (state == S_REG_LATCH);
    assign reg_bus.addr   = reg_addr;
    assign reg_bus.wdata  = data.word;

    assign ram_bus.word_addr = word_addr.word;
    assign ram_bus.set_waddr = (state == S_SET_WADDR);
    assign ram_bus.set_raddr = (state == S_SET_RADDR);
    assign ram_bus.wr_stb    = (state == S_RAM_STORE);
    assign ram_bus.wdata     = data.word;

    // read slots, low byte first
    always_comb begin
        rd_word.word = (op_q == spi_inst_pkg::op_read_ram) ? ram_bus.rdata : reg_bus.rdata;
        dout = '0;
        if (trans_begin) begin
            if (state == S_SLOT_LO)
                dout = rd_word.bytes.lo;
            else if (state == S_SLOT_HI)
                dout = rd_word.bytes.hi;
        end
    end

endmodule

//--- design/user_reg_file.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// user registers num1 to num3 plus readback of sum and en
// writes to sum, en or unknown addresses are dropped
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "spi_inst_params.svh"

module user_reg_file (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`SPI_INST_WORD_W-1:0] sum,
    input  logic                        en_state,
    output logic [`SPI_INST_WORD_W-1:0] num1,
    output logic [`SPI_INST_WORD_W-1:0] num2,
    output logic [`SPI_INST_WORD_W-1:0] num3,
    reg_access_if.regs                  reg_bus
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            num1 <= '0;
            num2 <= '0;
            num3 <= '0;
        end else if (reg_bus.wr_stb) begin
            case (reg_bus.addr)
                spi_inst_pkg::ra_num1: num1 <= reg_bus.wdata;
                spi_inst_pkg::ra_num2: num2 <= reg_bus.wdata;
                spi_inst_pkg::ra_num3: num3 <= reg_bus.wdata;
                default: ;
            endcase
        end
    end

    // snapshot at the strobe, held through both read slots
    always_ff @(posedge clk) begin
        if (reg_bus.rd_stb) begin
            case (reg_bus.addr)
                spi_inst_pkg::ra_sum:  reg_bus.rdata <= sum;
                spi_inst_pkg::ra_num1: reg_bus.rdata <= num1;
                spi_inst_pkg::ra_num2: reg_bus.rdata <= num2;
                spi_inst_pkg::ra_num3: reg_bus.rdata <= num3;
                spi_inst_pkg::ra_en:
                    reg_bus.rdata <= {{(`SPI_INST_WORD_W-1){1'b0}}, en_state};
                default: reg_bus.rdata <= '0;
            endcase
        end
    end

endmodule

//--- design/ram_port_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// port side of the external RAM, read path is combinational
// addresses at or above RAM_SIZE never write and read as zero
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "spi_inst_params.svh"

module ram_port_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`SPI_INST_WORD_W-1:0] ram_rdata,
    output logic                        ram_wreq,
    output logic [`SPI_INST_RAM_AW-1:0] ram_waddr,
    output logic [`SPI_INST_RAM_AW-1:0] ram_raddr,
    output logic [`SPI_INST_WORD_W-1:0] ram_wdata,
    ram_access_if.ram                   ram_bus
);

    logic in_range;

    assign in_range = (ram_bus.word_addr < `SPI_INST_RAM_SIZE);

    // address registers only move on the set pulses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ram_waddr <= '0;
            ram_raddr <= '0;
        end else begin
            if (ram_bus.set_waddr)
                ram_waddr <= ram_bus.word_addr[`SPI_INST_RAM_AW-1:0];
            if (ram_bus.set_raddr)
                ram_raddr <= ram_bus.word_addr[`SPI_INST_RAM_AW-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ram_wreq <= 1'b0;
        else
            ram_wreq <= ram_bus.wr_stb & in_range;
    end

    always_ff @(posedge clk) begin
        if (ram_bus.wr_stb)
            ram_wdata <= ram_bus.wdata;
    end

    // word_addr still matches ram_raddr during the read slots
    assign ram_bus.rdata = in_range ? ram_rdata : '0;

endmodule

//--- design/spi_inst_parser.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI instruction parser, little endian, byte-wide link
// no back-pressure, the SPI master sets the pace
// ram_rdata must follow ram_raddr combinationally
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "spi_inst_params.svh"

module spi_inst_parser (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        trans_begin,
    input  logic                        trans_end,
    input  logic [`SPI_INST_BYTE_W-1:0] din,
    output logic [`SPI_INST_BYTE_W-1:0] dout,
    input  logic [`SPI_INST_WORD_W-1:0] sum,
    output logic [`SPI_INST_WORD_W-1:0] num1,
    output logic [`SPI_INST_WORD_W-1:0] num2,
    output logic [`SPI_INST_WORD_W-1:0] num3,
    output logic                        en,
    output logic                        ram_wreq,
    output logic [`SPI_INST_RAM_AW-1:0] ram_waddr,
    output logic [`SPI_INST_WORD_W-1:0] ram_wdata,
    output logic [`SPI_INST_RAM_AW-1:0] ram_raddr,
    input  logic [`SPI_INST_WORD_W-1:0] ram_rdata
);

    reg_access_if reg_bus ();
    ram_access_if ram_bus ();

    inst_sequencer u_inst_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .trans_begin (trans_begin),
        .trans_end   (trans_end),
        .din         (din),
        .dout        (dout),
        .en          (en),
        .reg_bus     (reg_bus),
        .ram_bus     (ram_bus)
    );

    user_reg_file u_user_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .sum      (sum),
        .en_state (en),
        .num1     (num1),
        .num2     (num2),
        .num3     (num3),
        .reg_bus  (reg_bus)
    );

    ram_port_ctrl u_ram_port_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .ram_rdata (ram_rdata),
        .ram_wreq  (ram_wreq),
        .ram_waddr (ram_waddr),
        .ram_raddr (ram_raddr),
        .ram_wdata (ram_wdata),
        .ram_bus   (ram_bus)
    );

endmodule

//--- verification/spi_inst_checker.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// protocol assertions, bound into every spi_inst_parser
// assumes trans_end pulses are one cycle long
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "spi_inst_params.svh"

module spi_inst_checker (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        trans_begin,
    input logic                        trans_end,
    input logic [`SPI_INST_BYTE_W-1:0] dout,
    input logic                        en,
    input logic                        ram_wreq
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    wreq_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        ram_wreq |=> !ram_wreq)
        else begin
            fail_count++;
            $error("ram_wreq stayed high for two cycles");
        end

    // read data only leaves during a read slot
    dout_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !trans_begin |-> (dout == '0))
        else begin
            fail_count++;
            $error("dout is not zero while trans_begin is low");
        end

    // opcode byte, then one cycle of en update
    en_after_opcode: assert property (@(posedge clk) disable iff (!rst_n)
        (en != $past(en)) |-> $past(trans_end, 2))
        else begin
            fail_count++;
            $error("en changed without a captured opcode byte");
        end

endmodule

bind spi_inst_parser spi_inst_checker u_spi_inst_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .trans_begin (trans_begin),
    .trans_end   (trans_end),
    .dout        (dout),
    .en          (en),
    .ram_wreq    (ram_wreq)
);

//--- verification/tb_spi_inst_parser.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// random instruction test against a register and RAM model
// the model RAM doubles as the external RAM with a combinational read
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "spi_inst_params.svh"

module tb_spi_inst_parser;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_INST = 200;
    // 8-word burst is 21 transfers of 5 cycles
    localparam int INST_CYC = 120;
    localparam int CYC_LIMIT = (NUM_INST + 8) * INST_CYC + 50;

    logic                        clk;
    logic                        rst_n;
    logic                        trans_begin;
    logic                        trans_end;
    logic [`SPI_INST_BYTE_W-1:0] din;
    logic [`SPI_INST_BYTE_W-1:0] dout;
    logic [`SPI_INST_WORD_W-1:0] sum;
    logic [`SPI_INST_WORD_W-1:0] num1;
    logic [`SPI_INST_WORD_W-1:0] num2;
    logic [`SPI_INST_WORD_W-1:0] num3;
    logic                        en;
    logic                        ram_wreq;
    logic [`SPI_INST_RAM_AW-1:0] ram_waddr;
    logic [`SPI_INST_RAM_AW-1:0] ram_raddr;
    logic [`SPI_INST_WORD_W-1:0] ram_wdata;
    logic [`SPI_INST_WORD_W-1:0] ram_rdata;

    logic [`SPI_INST_WORD_W-1:0] ram_mem [`SPI_INST_RAM_SIZE];
    logic [`SPI_INST_WORD_W-1:0] num_model [1:3];
    logic                        en_model;
    logic [`SPI_INST_RAM_AW-1:0] exp_addr_q [$];
    logic [`SPI_INST_WORD_W-1:0] exp_data_q [$];
    int seed = 54;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int wreq_count = 0;

    assign ram_rdata = ram_mem[ram_raddr];

    spi_inst_parser u_spi_inst_parser (
        .clk (clk), .rst_n (rst_n), .trans_begin (trans_begin), .trans_end (trans_end),
        .din (din), .dout (dout), .sum (sum), .num1 (num1), .num2 (num2), .num3 (num3),
        .en (en), .ram_wreq (ram_wreq), .ram_waddr (ram_waddr), .ram_wdata (ram_wdata),
        .ram_raddr (ram_raddr), .ram_rdata (ram_rdata)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYC_LIMIT) begin
            $display("timeout after %0d cycles, the instruction stream did not finish", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic compare_word(input string name, input logic [15:0] exp,
                                input logic [15:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERR %s expected 0x%04h actual 0x%04h", name, exp, act);
        end
    endtask

    // external RAM write port
    always @(negedge clk) begin
        if (rst_n && ram_wreq) begin
            wreq_count++;
            checks++;
            assert (exp_addr_q.size() > 0) else begin
                errors++;
                $display("ram_wreq pulsed while no in-range word was pending");
            end
            if (exp_addr_q.size() > 0) begin
                compare_word("ram_waddr", exp_addr_q.pop_front(), ram_waddr);
                compare_word("ram_wdata", exp_data_q.pop_front(), ram_wdata);
            end
        end
    end

    task automatic next_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic send_byte(input logic [7:0] b);
        next_edge();
        trans_begin = 1'b1;
        next_edge();
        trans_begin = 1'b0;
        next_edge();
        din       = b;
        trans_end = 1'b1;
        next_edge();
        trans_end = 1'b0;
        din       = '0;
        next_edge();
    endtask

    task automatic read_slot(output logic [7:0] b);
        next_edge();
        trans_begin = 1'b1;
        #3;
        b = dout;
        next_edge();
        trans_begin = 1'b0;
        next_edge();
        trans_end = 1'b1;
        next_edge();
        trans_end = 1'b0;
        next_edge();
    endtask

    // low byte first
    task automatic read_word(input logic [15:0] exp);
        logic [7:0] lo;
        logic [7:0] hi;
        read_slot(lo);
        read_slot(hi);
        compare_word("dout", {8'h00, exp[7:0]}, {8'h00, lo});
        compare_word("dout", {8'h00, exp[15:8]}, {8'h00, hi});
    endtask

    function automatic logic [15:0] reg_expect(input logic [7:0] addr);
        case (addr)
            8'd0: return sum;
            8'd1, 8'd2, 8'd3: return num_model[addr];
            8'd4: return {15'd0, en_model};
            default: return '0;
        endcase
    endfunction

    task automatic read_reg(input logic [7:0] addr);
        send_byte(8'd3);
        send_byte(addr);
        read_word(reg_expect(addr));
    endtask

    task automatic check_outputs();
        compare_word("en", {15'd0, en_model}, {15'd0, en});
        compare_word("num1", num_model[1], num1);
        compare_word("num2", num_model[2], num2);
        compare_word("num3", num_model[3], num3);
    endtask

    task automatic ram_burst(input bit is_write);
        logic [15:0] first;
        logic [15:0] cnt;
        logic [15:0] data;
        int          in_range;
        int          pulses;
        // half of the bursts start close to the top of the RAM
        if ($random(seed) & 1)
            first = 16'd248 + 16'($unsigned($random(seed)) % 8);
        else
            first = 16'($unsigned($random(seed)) % 256);
        cnt = 16'(1 + $unsigned($random(seed)) % 8);
        send_byte(is_write ? 8'd6 : 8'd7);
        send_byte(first[7:0]);
        send_byte(first[15:8]);
        send_byte(cnt[7:0]);
        send_byte(cnt[15:8]);
        if (is_write) begin
            pulses   = wreq_count;
            in_range = 0;
            for (int i = 0; i < cnt; i++) begin
                data = $random(seed);
                if (first + i < `SPI_INST_RAM_SIZE) begin
                    exp_addr_q.push_back(first + i);
                    exp_data_q.push_back(data);
                    ram_mem[first + i] = data;
                    in_range++;
                end
                send_byte(data[7:0]);
                send_byte(data[15:8]);
            end
            repeat (2) next_edge();
            compare_word("ram_wreq pulses", 16'(in_range), 16'(wreq_count - pulses));
        end else begin
            for (int i = 0; i < cnt; i++)
                read_word((first + i < `SPI_INST_RAM_SIZE) ? ram_mem[first + i] : 16'h0);
        end
    endtask

    task automatic run_inst();
        int          kind;
        logic [7:0]  op;
        logic [7:0]  addr;
        logic [15:0] data;
        sum  = $random(seed);
        kind = $unsigned($random(seed)) % 6;
        case (kind)
            0: begin
                op = $random(seed) & 1;
                send_byte(op);
                en_model = op[0];
            end
            1: begin
                // 4, 5 and anything above 7 fall back to idle
                if ($random(seed) & 1) begin
                    op = 8'd4 + 8'($unsigned($random(seed)) % 2);
                end else begin
                    op = $random(seed);
                    while (op inside {[8'd0:8'd3], 8'd6, 8'd7})
                        op = $random(seed);
                end
                send_byte(op);
            end
            2: begin
                addr = $random(seed) & 7;
                data = $random(seed);
                send_byte(8'd2);
                send_byte(addr);
                send_byte(data[7:0]);
                send_byte(data[15:8]);
                if (addr inside {[8'd1:8'd3]})
                    num_model[addr] = data;
            end
            3: read_reg($random(seed) & 7);
            default: ram_burst(kind == 4);
        endcase
        check_outputs();
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        trans_begin = 1'b0;
        trans_end   = 1'b0;
        din         = '0;
        sum         = '0;
        en_model    = 1'b0;
        for (int i = 1; i <= 3; i++)
            num_model[i] = '0;
        for (int i = 0; i < `SPI_INST_RAM_SIZE; i++)
            ram_mem[i] = 16'(i * 16'h9e37) ^ 16'h5ac3;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_edge();
        check_outputs();
        compare_word("ram_wreq", 16'h0, {15'd0, ram_wreq});
        compare_word("dout", 16'h0, {8'h00, dout});
        repeat (NUM_INST)
            run_inst();
        // every address once including the unknown ones
        for (int a = 0; a < 8; a++) begin
            sum = $random(seed);
            read_reg(8'(a));
        end
        errors += u_spi_inst_parser.u_spi_inst_checker.fail_count;
        $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
                 u_spi_inst_parser.u_spi_inst_checker.fail_count);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- spi_inst_parser.f
+incdir+design
design/spi_inst_pkg.sv
design/spi_inst_ifs.sv
design/inst_sequencer.sv
design/user_reg_file.sv
design/ram_port_ctrl.sv
design/spi_inst_parser.sv
verification/spi_inst_checker.sv
verification/tb_spi_inst_parser.sv
